// File: list.f
+incdir+rtl
rtl/bb_tx_pkg.sv
rtl/sym_if.sv
rtl/symbol_framer.sv
rtl/upsampler.sv
rtl/pulse_shaper.sv
rtl/bb_tx_top.sv
verif/bb_tx_assertions.sv
verif/tb_bb_tx.sv

// File: rtl/bb_tx_cfg.svh
`ifndef BB_TX_CFG_SVH
`define BB_TX_CFG_SVH

// width of one I or Q level in two's complement.
`define BB_TX_LEVEL_W 4

// shaped sample width. 6 x 3 = 18 is the largest magnitude, so 7 bits hold it.
`define BB_TX_OUT_W 7

// width of the sample_rate input and of the latched factor.
`define BB_TX_RATE_W 4

// factors below this are raised to it by the framer.
`define BB_TX_RATE_MIN 2

// factor held by the framer while in reset.
`define BB_TX_RATE_RESET 4

`endif

// File: rtl/bb_tx_pkg.sv
`include "bb_tx_cfg.svh"

package bb_tx_pkg;

    // one I or Q symbol level. Only -3, -1, +1 and +3 are legal.
    typedef logic signed [`BB_TX_LEVEL_W-1:0] level_t;

    // output of the pulse shaper on one rail.
    typedef logic signed [`BB_TX_OUT_W-1:0] shaped_t;

    // unsigned upsampling factor.
    typedef logic [`BB_TX_RATE_W-1:0] rate_t;

    // the four 16-QAM levels on each rail.
    localparam level_t LVL_NEG3 = level_t'(-3);
    localparam level_t LVL_NEG1 = level_t'(-1);
    localparam level_t LVL_POS1 = level_t'(1);
    localparam level_t LVL_POS3 = level_t'(3);

    // Gray mapping of one bit pair, so that neighbouring levels differ in one bit.
    function automatic level_t gray_level(input logic [1:0] bits);
        level_t lvl;
        case (bits)
            2'b00:   lvl = LVL_NEG3;
            2'b01:   lvl = LVL_NEG1;
            2'b11:   lvl = LVL_POS1;
            default: lvl = LVL_POS3;  // 2'b10.
        endcase
        return lvl;
    endfunction

endpackage

// File: rtl/bb_tx_top.sv
module bb_tx_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,
    input  bb_tx_pkg::rate_t    sample_rate,
    input  logic [3:0]          data_in,
    output logic                data_req,
    output logic                out_valid,
    output bb_tx_pkg::shaped_t  out_i,
    output bb_tx_pkg::shaped_t  out_q
);

    bb_tx_pkg::level_t up_i;
    bb_tx_pkg::level_t up_q;
    logic              up_active;

    sym_if i_sym_if ();

    symbol_framer i_framer (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .sample_rate (sample_rate),
        .data_in     (data_in),
        .data_req    (data_req),
        .sym         (i_sym_if.source)
    );

    upsampler i_upsampler (
        .clk    (clk),
        .rst_n  (rst_n),
        .sym    (i_sym_if.sink),
        .up_i   (up_i),
        .up_q   (up_q),
        .active (up_active)
    );

    // one shaper per rail.
    pulse_shaper i_shaper_i (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (up_i),
        .y     (out_i)
    );

    pulse_shaper i_shaper_q (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (up_q),
        .y     (out_q)
    );

    // the shapers add one cycle, so the valid flag is delayed to match.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= up_active;
        end
    end

endmodule

// File: rtl/pulse_shaper.sv
`include "bb_tx_cfg.svh"

module pulse_shaper (
    input  logic                clk,
    input  logic                rst_n,
    input  bb_tx_pkg::level_t   x,
    output bb_tx_pkg::shaped_t  y
);

    localparam int EXT_W = `BB_TX_OUT_W - `BB_TX_LEVEL_W;

    bb_tx_pkg::level_t  x_d1;
    bb_tx_pkg::level_t  x_d2;
    bb_tx_pkg::level_t  x_d3;
    bb_tx_pkg::shaped_t tap0;
    bb_tx_pkg::shaped_t tap1;
    bb_tx_pkg::shaped_t tap2;
    bb_tx_pkg::shaped_t tap3;
    bb_tx_pkg::shaped_t sum;

    function automatic bb_tx_pkg::shaped_t sext(input bb_tx_pkg::level_t v);
        return {{EXT_W{v[`BB_TX_LEVEL_W-1]}}, v};
    endfunction

    // Delay line. Cleared so that the first symbol after reset sees no history.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_d1 <= '0;
            x_d2 <= '0;
            x_d3 <= '0;
        end else begin
            x_d1 <= x;
            x_d2 <= x_d1;
            x_d3 <= x_d2;
        end
    end

    // triangular taps 1, 2, 2, 1.
    always_comb begin
        tap0 = sext(x);
        tap1 = sext(x_d1) <<< 1;
        tap2 = sext(x_d2) <<< 1;
        tap3 = sext(x_d3);
        sum  = tap0 + tap1 + tap2 + tap3;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else begin
            y <= sum;  // one cycle after the input sample.
        end
    end

endmodule

// File: rtl/sym_if.sv
interface sym_if;

    logic                 new_symbol;  // one-cycle pulse per symbol.
    bb_tx_pkg::level_t    sym_i;       // valid while new_symbol is high.
    bb_tx_pkg::level_t    sym_q;
    bb_tx_pkg::rate_t     rate;        // stable across a whole symbol period.

    modport source (
        output new_symbol,
        output sym_i,
        output sym_q,
        output rate
    );

    modport sink (
        input  new_symbol,
        input  sym_i,
        input  sym_q,
        input  rate
    );

endinterface

// File: rtl/symbol_framer.sv
`include "bb_tx_cfg.svh"

module symbol_framer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,
    input  bb_tx_pkg::rate_t    sample_rate,
    input  logic [3:0]          data_in,
    output logic                data_req,
    sym_if.source               sym
);

    bb_tx_pkg::rate_t rate_clamped;
    bb_tx_pkg::rate_t period_cnt;  // cycles left in the current symbol period.
    bb_tx_pkg::rate_t period_q;    // factor taken at the last data_req.

    // factors of 0 and 1 would break the zero insertion, so they run as the minimum.
    always_comb begin
        if (sample_rate < bb_tx_pkg::rate_t'(`BB_TX_RATE_MIN)) begin
            rate_clamped = bb_tx_pkg::rate_t'(`BB_TX_RATE_MIN);
        end else begin
            rate_clamped = sample_rate;
        end
    end

    // The counter reaches zero on the last cycle of a period. A request is raised on
    // the next edge and the new factor is taken at the same time.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
            period_q   <= bb_tx_pkg::rate_t'(`BB_TX_RATE_RESET);
            data_req   <= 1'b0;
        end else if (!enable) begin
            period_cnt <= '0;  // so the first request follows enable at once.
            data_req   <= 1'b0;
        end else if (period_cnt == '0) begin
            period_cnt <= rate_clamped - 1'b1;
            period_q   <= rate_clamped;
            data_req   <= 1'b1;
        end else begin
            period_cnt <= period_cnt - 1'b1;
            data_req   <= 1'b0;
        end
    end

    // new_symbol follows data_req by one cycle. The rate is handed over only here,
    // so the upsampler never sees it change in the middle of a period.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym.new_symbol <= 1'b0;
            sym.rate       <= bb_tx_pkg::rate_t'(`BB_TX_RATE_RESET);
        end else begin
            sym.new_symbol <= data_req;
            if (data_req) begin
                sym.rate <= period_q;
            end
        end
    end

    // data_in is sampled at the end of the request cycle.
    // upper pair drives I, lower pair drives Q.
    always_ff @(posedge clk) begin
        if (data_req) begin
            sym.sym_i <= bb_tx_pkg::gray_level(data_in[3:2]);
            sym.sym_q <= bb_tx_pkg::gray_level(data_in[1:0]);
        end
    end

endmodule

// File: rtl/upsampler.sv
module upsampler (
    input  logic                clk,
    input  logic                rst_n,
    sym_if.sink                 sym,
    output bb_tx_pkg::level_t   up_i,
    output bb_tx_pkg::level_t   up_q,
    output logic                active
);

    typedef enum logic {
        S_IDLE,
        S_SAMPLING
    } state_t;

    state_t            state;
    state_t            state_nxt;
    bb_tx_pkg::rate_t  sample_cnt;  // index of the current output within the period.
    bb_tx_pkg::rate_t  sample_cnt_nxt;
    bb_tx_pkg::level_t up_i_nxt;
    bb_tx_pkg::level_t up_q_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            sample_cnt <= '0;
            up_i       <= '0;
            up_q       <= '0;
        end else begin
            state      <= state_nxt;
            sample_cnt <= sample_cnt_nxt;
            up_i       <= up_i_nxt;
            up_q       <= up_q_nxt;
        end
    end

    always_comb begin
        state_nxt      = state;
        sample_cnt_nxt = sample_cnt;
        up_i_nxt       = '0;  // zero padding unless a symbol is loaded.
        up_q_nxt       = '0;

        if (sym.new_symbol) begin
            // a symbol landing on the last zero starts the next period seamlessly.
            state_nxt      = S_SAMPLING;
            sample_cnt_nxt = '0;
            up_i_nxt       = sym.sym_i;
            up_q_nxt       = sym.sym_q;
        end else begin
            case (state)
                S_IDLE: begin
                    sample_cnt_nxt = '0;
                end
                S_SAMPLING: begin
                    if (sample_cnt == sym.rate - 1'b1) begin
                        state_nxt      = S_IDLE;  // last zero of the period is out.
                        sample_cnt_nxt = '0;
                    end else begin
                        sample_cnt_nxt = sample_cnt + 1'b1;
                    end
                end
                default: begin
                    state_nxt      = S_IDLE;
                    sample_cnt_nxt = '0;
                end
            endcase
        end
    end

    // high from the symbol sample through the last zero of its period.
    assign active = (state == S_SAMPLING);

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f list.f --top-module tb_bb_tx -o sim_bb_tx > build.log 2>&1 \
    && ./obj_dir/sim_bb_tx > sim.log 2>&1 \
    || echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q '\*\*\* FAILED \*\*\*' sim.log 2>/dev/null && echo "simulation failed" && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null && echo "simulation passed" && exit 0
echo "no result found in sim.log" && exit 1

// File: verif/bb_tx_assertions.sv
`include "bb_tx_cfg.svh"

module bb_tx_assertions (
    input logic              clk,
    input logic              rst_n,
    input logic              new_symbol,
    input bb_tx_pkg::rate_t  rate,
    input bb_tx_pkg::level_t up_i,
    input bb_tx_pkg::level_t up_q
);

    timeunit 1ns;
    timeprecision 1ps;

    // with a factor of two or more every symbol is followed by at least one zero slot.
    symbol_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        (new_symbol && rate >= bb_tx_pkg::rate_t'(`BB_TX_RATE_MIN)) |=> !new_symbol
    ) else $error("new_symbol was high on two consecutive cycles.");

    rate_floor: assert property (
        @(posedge clk) disable iff (!rst_n)
        rate >= bb_tx_pkg::rate_t'(`BB_TX_RATE_MIN)
    ) else $error("upsampling factor %0d is below the minimum.", rate);

    // only the cycle right after new_symbol may carry a level.
    zero_padding: assert property (
        @(posedge clk) disable iff (!rst_n)
        !new_symbol |=> (up_i == '0 && up_q == '0)
    ) else $error("nonzero sample %0d/%0d outside a symbol slot.", up_i, up_q);

endmodule

// File: verif/tb_bb_tx.sv
`include "bb_tx_cfg.svh"

module tb_bb_tx;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_SYMBOLS = 82;  // 16 + 20 + 3 + 40 + 3 symbols over all tests.
    localparam int TIMEOUT_NS   = TEST_SYMBOLS * 15 * CLK_PERIOD + 20000;
    localparam int WAIT_LIMIT   = 64;

    logic               clk;
    logic               rst_n;
    logic               enable;
    bb_tx_pkg::rate_t   sample_rate;
    logic [3:0]         data_in;
    logic               data_req;
    logic               out_valid;
    bb_tx_pkg::shaped_t out_i;
    bb_tx_pkg::shaped_t out_q;

    int          error_count;
    int          check_count;
    logic [3:0]  word_q[$];  // words still to be handed out on data_req.

    // reference model state, advanced on every rising edge.
    bit m_first;   // the next enabled cycle raises a request.
    bit m_req;
    int m_gap;     // cycles since the last request.
    int m_len;     // period taken at the last request.
    bit m_ns;
    int m_sym_i;
    int m_sym_q;
    int m_sym_len;
    int m_left;    // samples of the current period still to come.
    bit m_active;
    int m_x_i[4];  // upsampled I, newest first.
    int m_x_q[4];
    int m_out_i;
    int m_out_q;
    bit m_valid;

    bb_tx_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .sample_rate (sample_rate),
        .data_in     (data_in),
        .data_req    (data_req),
        .out_valid   (out_valid),
        .out_i       (out_i),
        .out_q       (out_q)
    );

    bind upsampler bb_tx_assertions i_assertions (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_symbol (sym.new_symbol),
        .rate       (sym.rate),
        .up_i       (up_i),
        .up_q       (up_q)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // the Gray map runs 00, 01, 11, 10 from -3 up to +3.
    function automatic int level_of(input logic [1:0] bits);
        int lvl;
        case (bits)
            2'b00:   lvl = -3;
            2'b01:   lvl = -1;
            2'b11:   lvl = 1;
            default: lvl = 3;
        endcase
        return lvl;
    endfunction

    function automatic int tap_weight(input int k);
        return (k == 0 || k == 3) ? 1 : 2;  // triangle 1, 2, 2, 1.
    endfunction

    function automatic int clamped_rate(input int r);
        return (r < `BB_TX_RATE_MIN) ? `BB_TX_RATE_MIN : r;
    endfunction

    task automatic check_value(input string what, input int actual, input int expected);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("** Error at %0d ns: %s is %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    task automatic expect_quiet(input string when);
        check_value({"data_req ", when}, data_req, 0);
        check_value({"out_valid ", when}, out_valid, 0);
        check_value({"out_i ", when}, out_i, 0);
        check_value({"out_q ", when}, out_q, 0);
    endtask

    // gap counts the falling edges from the call up to the one that sees data_req.
    task automatic wait_for_req(input string what, output int gap);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!data_req && gap < WAIT_LIMIT);
        if (!data_req) begin
            error_count++;
            $display("data_req did not arrive within %0d cycles during %s.", WAIT_LIMIT, what);
        end
    endtask

    task automatic wait_for_drain(input string what);
        int n;
        n = 0;
        repeat (3) @(negedge clk);  // lets the last symbol reach the output.
        while (out_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (out_valid) begin
            error_count++;
            $display("out_valid stayed high for %0d cycles during %s.", WAIT_LIMIT, what);
        end
        repeat (3) @(negedge clk);
        expect_quiet({"after ", what});
    endtask

    // hands the next queued word over while data_req is high.
    initial begin
        data_in = '0;
        forever begin
            @(negedge clk);
            if (data_req) begin
                data_in = (word_q.size() > 0) ? word_q.pop_front() : 4'h0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            m_first  = 1'b1;
            m_req    = 1'b0;
            m_gap    = 0;
            m_len    = `BB_TX_RATE_RESET;
            m_ns     = 1'b0;
            m_left   = 0;
            m_active = 1'b0;
            m_valid  = 1'b0;
            m_out_i  = 0;
            m_out_q  = 0;
            m_x_i    = '{0, 0, 0, 0};
            m_x_q    = '{0, 0, 0, 0};
        end else begin
            // stages are updated from the output backwards, so each sees last cycle's state.
            m_out_i = m_x_i[0] + 2 * m_x_i[1] + 2 * m_x_i[2] + m_x_i[3];
            m_out_q = m_x_q[0] + 2 * m_x_q[1] + 2 * m_x_q[2] + m_x_q[3];
            m_valid = m_active;
            for (int k = 3; k > 0; k--) begin
                m_x_i[k] = m_x_i[k-1];
                m_x_q[k] = m_x_q[k-1];
            end
            m_x_i[0] = m_ns ? m_sym_i : 0;
            m_x_q[0] = m_ns ? m_sym_q : 0;
            if (m_ns) begin
                m_left = m_sym_len;
            end else if (m_left > 0) begin
                m_left--;
            end
            m_active = (m_left > 0);
            m_ns = m_req;
            if (m_req) begin
                m_sym_i   = level_of(data_in[3:2]);
                m_sym_q   = level_of(data_in[1:0]);
                m_sym_len = m_len;
            end
            if (!enable) begin
                m_req   = 1'b0;
                m_first = 1'b1;
            end else if (m_first || m_gap >= m_len) begin
                m_req   = 1'b1;
                m_first = 1'b0;
                m_gap   = 1;
                m_len   = clamped_rate(sample_rate);
            end else begin
                m_req = 1'b0;
                m_gap++;
            end
        end
    end

    always @(negedge clk) begin
        check_value("data_req", data_req, m_req);
        check_value("out_valid", out_valid, m_valid);
        check_value("out_i", out_i, m_out_i);
        check_value("out_q", out_q, m_out_q);
    end

    task automatic run_reset();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            expect_quiet("in reset");
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            expect_quiet("after reset");
        end
    endtask

    task automatic send_constellation();
        int gap;
        int reqs;
        int w;
        for (int k = 0; k < 16; k++) word_q.push_back(4'(k));
        sample_rate = 4'd4;
        enable      = 1'b1;
        wait_for_req("constellation", gap);
        reqs = 1;
        repeat (2) @(negedge clk);
        for (int j = 0; j < 64; j++) begin
            @(negedge clk);  // first pass lands three cycles after the request.
            w = j / 4;
            check_value("constellation out_i", out_i, level_of(w[3:2]) * tap_weight(j % 4));
            check_value("constellation out_q", out_q, level_of(w[1:0]) * tap_weight(j % 4));
            if (data_req) begin
                reqs++;
                if (reqs == 16) enable = 1'b0;
            end
        end
        enable = 1'b0;
        wait_for_drain("constellation");
        check_value("words left after constellation", word_q.size(), 0);
    endtask

    task automatic measure_spacing(input int rate_in, input int expected);
        int gap;
        sample_rate = 4'(rate_in);
        enable      = 1'b1;
        wait_for_req("spacing", gap);
        repeat (3) begin
            wait_for_req("spacing", gap);
            check_value($sformatf("request gap at rate %0d", rate_in), gap, expected);
        end
        enable = 1'b0;
        wait_for_drain("spacing");
    endtask

    task automatic change_rate_mid_period();
        int gap;
        sample_rate = 4'd3;
        enable      = 1'b1;
        wait_for_req("rate change", gap);
        @(negedge clk);
        sample_rate = 4'd6;  // lands between two requests.
        wait_for_req("rate change", gap);
        check_value("gap before the rate change", gap + 1, 3);
        wait_for_req("rate change", gap);
        check_value("gap after the rate change", gap, 6);
        enable = 1'b0;
        wait_for_drain("rate change");
    endtask

    task automatic stream_random_overlap();
        int gap;
        for (int k = 0; k < 40; k++) word_q.push_back(4'($urandom));
        sample_rate = 4'd2;
        enable      = 1'b1;
        for (int k = 0; k < 40; k++) wait_for_req("random overlap", gap);
        enable = 1'b0;
        wait_for_drain("random overlap");
        check_value("words left after random overlap", word_q.size(), 0);
    endtask

    task automatic drop_enable();
        int gap;
        sample_rate = 4'd5;
        enable      = 1'b1;
        repeat (3) wait_for_req("enable drop", gap);
        repeat (2) @(negedge clk);
        enable = 1'b0;  // this lands mid-period and the symbol in flight still drains.
        @(negedge clk);
        check_value("out_valid while draining", out_valid, 1);
        repeat (20) begin
            @(negedge clk);
            check_value("data_req after enable fell", data_req, 0);
        end
        expect_quiet("after enable drop");
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns.", TIMEOUT_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(1));
        error_count = 0;
        check_count = 0;
        rst_n       = 1'b0;
        enable      = 1'b0;
        sample_rate = '0;
        run_reset();
        send_constellation();
        measure_spacing(2, 2);
        measure_spacing(5, 5);
        measure_spacing(15, 15);
        measure_spacing(0, 2);
        measure_spacing(1, 2);
        change_rate_mid_period();
        stream_random_overlap();
        drop_enable();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
